//--- Bender.yml
package:
  name: risc_core

sources:
  - verilog/risc_pkg.sv
  - verilog/fetch_unit.sv
  - verilog/instr_decoder.sv
  - verilog/alu.sv
  - verilog/file_regs.sv
  - verilog/risc_core.sv
  - target: simulation
    files:
      - tb/tb_clkgen.sv
      - tb/risc_tb.sv

//--- tb/risc_tb.sv
`timescale 1ns/1ps

module risc_tb import risc_pkg::*; ();

    localparam int          PC_W       = PC_W_DEF;
    localparam int          DRIVE_DLY  = 1;
    localparam int          RAND_COUNT = 120;   // Random instructions between setup and dump
    localparam int          RUN_LIMIT  = 2000;
    localparam int          RST_LIMIT  = 20;
    localparam int          DRAIN      = 4;     // Device write lags its fetch by two cycles
    localparam logic [31:0] SEED       = 32'he2a8_e8e6;

    logic            clk, rst;
    logic [PC_W-1:0] imem_addr;
    instr_t          imem_data;
    logic            dvc_wr, dvc_rd;
    dvc_addr_t       dvc_wr_addr, dvc_rd_addr;
    byte_t           data_mem2dvc, data_dvc2mem;

    instr_t          rom [2**PC_W];
    logic [PC_W-1:0] fetch_addr;
    logic [PC_W-1:0] loop_pc;   // Final GOTO to itself
    int              prog_len;
    logic [31:0]     lfsr_state;

    // Instruction-set model state
    int              m_pc;
    byte_t           m_w;
    logic            m_z, m_c;
    byte_t           m_gpr [2**FILE_AW - GPR_BASE];
    dvc_addr_t       exp_port [$];
    byte_t           exp_data [$];

    int              value_errors, other_errors;
    int              wr_count, rd_checks;

    tb_clkgen #(.PERIOD(20), .RST_CYCLES(4), .DRIVE_DLY(DRIVE_DLY)) clkgen_i (
        .clk (clk),
        .rst (rst)
    );

    risc_core #(.PC_W(PC_W)) dut_i (
        .clk          (clk),
        .rst          (rst),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dvc_wr       (dvc_wr),
        .dvc_rd       (dvc_rd),
        .dvc_wr_addr  (dvc_wr_addr),
        .dvc_rd_addr  (dvc_rd_addr),
        .data_mem2dvc (data_mem2dvc),
        .data_dvc2mem (data_dvc2mem)
    );

    // Fixed input value of each device port
    function automatic byte_t port_value(input dvc_addr_t p);
        case (p)
            2'd0:    return 8'h3c;
            2'd1:    return 8'h81;
            2'd2:    return 8'h6d;
            default: return 8'hf7;
        endcase
    endfunction

    assign data_dvc2mem = port_value(dvc_rd_addr);

    always @(negedge clk)
        fetch_addr = imem_addr;   // Stable mid-cycle

    always @(posedge clk)
    begin
        #(DRIVE_DLY);
        imem_data = rom[fetch_addr];
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic instr_t byte_instr(input logic [3:0] op, input logic d, input faddr_t f);
        return {2'b00, op, d, f};
    endfunction

    function automatic instr_t lit_instr(input logic [1:0] sel, input byte_t k);
        return {2'b11, sel, k};
    endfunction

    function automatic instr_t goto_instr(input int t);
        return {3'b101, 9'(t)};
    endfunction

    task automatic emit(input instr_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    // Destination is mostly a general register, now and then a port
    function automatic faddr_t random_dest();
        if (rand_bits(3) == 0)
            return faddr_t'(DVC_BASE + rand_bits(2));
        return faddr_t'(GPR_BASE + rand_bits(4));
    endfunction

    function automatic faddr_t random_src();
        if (rand_bits(3) == 0)
            return faddr_t'(rand_bits(3));   // Zero, status or port
        return faddr_t'(GPR_BASE + rand_bits(4));
    endfunction

    function automatic instr_t random_byte_op();
        logic [3:0] op;
        logic       d;
        op = 4'(rand_bits(4));
        d  = 1'(rand_bits(1));
        if (op == 4'hB)
            op = 4'h7;   // Unused codes fold onto ADDWF and SUBWF
        else if (op == 4'hF)
            op = 4'h2;
        if (op == 4'h0)
            d = 1'b1;
        if (op == 4'h1 && !d)
            return 12'h040;   // CLRW
        if (d && op != 4'h8)
            return byte_instr(op, d, random_dest());
        return byte_instr(op, d, random_src());
    endfunction

    task automatic emit_random(input int count);
        int end_pc;
        int kind;
        int t;
        end_pc = prog_len + count;
        while (prog_len < end_pc)
        begin
            kind = int'(rand_bits(4));
            if (kind == 14)
            begin
                t = prog_len + 1 + int'(rand_bits(2));   // Forward only
                if (t > end_pc)
                    t = end_pc;
                emit(goto_instr(t));
            end
            else if (kind >= 10)
                emit(lit_instr(2'(kind - 10), byte_t'(rand_bits(8))));
            else
                emit(random_byte_op());
        end
    endtask

    task automatic build_program();
        int i;
        for (i = 0; i < 2**PC_W; i++)
            rom[i] = '0;
        prog_len = 0;
        // Port read sits at address 0, so it is also the word seen in reset
        emit(byte_instr(4'h8, 1'b0, 5'd6));   // Device input into W
        emit(byte_instr(4'h0, 1'b1, 5'd5));
        for (i = GPR_BASE; i < 2**FILE_AW; i++)
            emit(byte_instr(4'h1, 1'b1, faddr_t'(i)));   // CLRF
        for (i = 0; i < 4; i++)
        begin
            emit(lit_instr(2'(i), byte_t'(rand_bits(8))));
            emit(byte_instr(4'h0, 1'b1, faddr_t'(DVC_BASE + i)));
        end
        emit_random(RAND_COUNT);
        // Dump of W, status and the general registers
        emit(byte_instr(4'h0, 1'b1, 5'd4));
        emit(byte_instr(4'h8, 1'b0, STATUS_ADDR));
        emit(byte_instr(4'h0, 1'b1, 5'd5));
        for (i = GPR_BASE; i < 2**FILE_AW; i++)
        begin
            emit(byte_instr(4'h8, 1'b0, faddr_t'(i)));
            emit(byte_instr(4'h0, 1'b1, faddr_t'(DVC_BASE + i % 4)));
        end
        loop_pc = PC_W'(prog_len);
        emit(goto_instr(prog_len));
    endtask

    function automatic byte_t model_read(input faddr_t f);
        byte_t v;
        v = '0;
        if (f >= GPR_BASE)
            v = m_gpr[f - GPR_BASE];
        else if (f >= DVC_BASE)
            v = port_value(dvc_addr_t'(f - DVC_BASE));
        else if (f == STATUS_ADDR)
        begin
            v[Z_BIT] = m_z;
            v[C_BIT] = m_c;
        end
        return v;
    endfunction

    task automatic model_write(input faddr_t f, input byte_t v);
        if (f >= GPR_BASE)
            m_gpr[f - GPR_BASE] = v;
        else if (f >= DVC_BASE)
        begin
            exp_port.push_back(dvc_addr_t'(f - DVC_BASE));
            exp_data.push_back(v);
        end
    endtask

    task automatic model_step(input instr_t iw);
        logic [3:0] op;
        logic       d, known, dest_w, dest_f, upd_z, upd_c, new_c;
        faddr_t     f;
        byte_t      fv, res;
        op     = iw[9:6];
        d      = iw[5];
        f      = iw[4:0];
        fv     = model_read(f);
        res    = '0;
        new_c  = m_c;
        upd_z  = 1'b0;
        upd_c  = 1'b0;
        dest_w = 1'b0;
        dest_f = 1'b0;
        m_pc   = m_pc + 1;
        if (iw[11:9] == 3'b101)
            m_pc = int'(iw[8:0]);   // GOTO
        else if (iw[11:10] == 2'b11)
        begin
            dest_w = 1'b1;
            upd_z  = (iw[9:8] != 2'b00);   // MOVLW keeps Z
            case (iw[9:8])
                2'b00:   res = iw[7:0];
                2'b01:   res = m_w | iw[7:0];
                2'b10:   res = m_w & iw[7:0];
                default: res = m_w ^ iw[7:0];
            endcase
        end
        else if (iw[11:10] == 2'b00)
        begin
            case (op)
                4'h0:    res = m_w;
                4'h1:    res = '0;
                4'h2:    {new_c, res} = {1'b1, fv} - {1'b0, m_w};   // Carry is no borrow
                4'h3:    res = fv - 8'd1;
                4'h4:    res = m_w | fv;
                4'h5:    res = m_w & fv;
                4'h6:    res = m_w ^ fv;
                4'h7:    {new_c, res} = {1'b0, fv} + {1'b0, m_w};
                4'h8:    res = fv;
                4'h9:    res = ~fv;
                4'hA:    res = fv + 8'd1;
                4'hC:    {res, new_c} = {m_c, fv};
                4'hD:    {new_c, res} = {fv, m_c};
                4'hE:    res = {fv[3:0], fv[7:4]};
                default: res = '0;
            endcase
            known  = (op != 4'hB) && (op != 4'hF);
            upd_c  = (op == 4'h2) || (op == 4'h7) || (op == 4'hC) || (op == 4'hD);
            upd_z  = known && op != 4'h0 && op != 4'hC && op != 4'hD && op != 4'hE;
            dest_f = known && d && op != 4'h8;
            dest_w = known && !d && op != 4'h0;
            if (op == 4'h1 && !d && f != 5'd0)   // Only the exact CLRW word clears
            begin
                upd_z  = 1'b0;
                dest_w = 1'b0;
            end
        end
        if (upd_z)
            m_z = (res == 8'h00);
        if (upd_c)
            m_c = new_c;
        if (dest_w)
            m_w = res;
        if (dest_f)
            model_write(f, res);
    endtask

    task automatic run_model();
        int steps;
        m_pc  = 0;
        m_w   = '0;
        m_z   = 1'b0;
        m_c   = 1'b0;
        steps = 0;
        while (m_pc != int'(loop_pc) && steps < RUN_LIMIT)
        begin
            model_step(rom[m_pc]);
            steps++;
        end
        if (m_pc != int'(loop_pc))
        begin
            $display("Model never reached the final loop");
            other_errors++;
        end
    endtask

    task automatic check_data(input byte_t got, input byte_t exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_port(input dvc_addr_t got, input dvc_addr_t exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_addr(input logic [PC_W-1:0] got, input logic [PC_W-1:0] exp,
                              input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // Device writes in order, and read strobes for MOVF from a port
    always @(negedge clk)
    begin
        if (rst === 1'b0 && dvc_wr === 1'b1)
        begin
            if (wr_count < exp_port.size())
            begin
                check_port(dvc_wr_addr, exp_port[wr_count], $sformatf("write %0d port", wr_count));
                check_data(data_mem2dvc, exp_data[wr_count], $sformatf("write %0d data", wr_count));
            end
            else
            begin
                $display("Device write %0d at %0t was not expected", wr_count, $time);
                other_errors++;
            end
            wr_count++;
        end
        if (rst === 1'b0 && imem_data[11:6] == 6'b001000 && imem_data[4:2] == 3'b001)
        begin
            check_bit(dvc_rd, 1'b1, "dvc_rd on MOVF from port");
            check_port(dvc_rd_addr, dvc_addr_t'(imem_data[4:0] - DVC_BASE), "dvc_rd_addr");
            rd_checks++;
        end
    end

    initial
    begin
        int   cycles;
        logic ok;
        imem_data    = '0;
        fetch_addr   = '0;
        value_errors = 0;
        other_errors = 0;
        wr_count     = 0;
        rd_checks    = 0;
        ok           = 1'b1;
        lfsr_state   = SEED;
        build_program();
        run_model();

        @(posedge clk);
        @(negedge clk);
        cycles = 0;
        while (rst && cycles < RST_LIMIT)
        begin
            check_addr(imem_addr, '0, "fetch address in reset");
            check_bit(dvc_wr, 1'b0, "dvc_wr in reset");
            check_bit(dvc_rd, 1'b0, "dvc_rd in reset");
            @(negedge clk);
            cycles++;
        end
        if (rst)
        begin
            $display("Timeout: reset was never released");
            other_errors++;
            ok = 1'b0;
        end

        if (ok)
        begin
            cycles = 0;
            while (imem_addr !== loop_pc && cycles < RUN_LIMIT)
            begin
                @(negedge clk);
                cycles++;
            end
            if (imem_addr !== loop_pc)
            begin
                $display("Timeout: core never reached the final loop at %0d", loop_pc);
                other_errors++;
                ok = 1'b0;
            end
        end

        if (ok)
        begin
            repeat (DRAIN) @(negedge clk);
            if (wr_count != exp_port.size())
            begin
                $display("Saw %0d device writes but expected %0d", wr_count, exp_port.size());
                other_errors++;
            end
            if (rd_checks == 0)
            begin
                $display("No MOVF from a device port was seen in decode");
                other_errors++;
            end
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen
#(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 4,
    parameter int DRIVE_DLY  = 1
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #(DRIVE_DLY) rst = 1'b0;   // Released just after an edge
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu import risc_pkg::*;
(
    input  alu_op_e op,
    input  byte_t   a,
    input  byte_t   b,
    input  logic    c_in,
    output byte_t   y,
    output logic    c_out
);

    logic [DATA_W:0] sum;
    logic [DATA_W:0] diff;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, b} - {1'b0, a};   // MSB is the borrow

    always_comb
    begin
        c_out = c_in;   // Carry holds for the non-carry operations
        case (op)
            ALU_ADD:
            begin
                y     = sum[DATA_W-1:0];
                c_out = sum[DATA_W];
            end
            ALU_SUB:
            begin
                y     = diff[DATA_W-1:0];
                c_out = ~diff[DATA_W];   // Set when b >= a
            end
            // Rotates go through the carry
            ALU_ROR:
            begin
                y     = {c_in, b[DATA_W-1:1]};
                c_out = b[0];
            end
            ALU_ROL:
            begin
                y     = {b[DATA_W-2:0], c_in};
                c_out = b[DATA_W-1];
            end
            ALU_OR:     y = a | b;
            ALU_XOR:    y = a ^ b;
            ALU_AND:    y = a & b;
            ALU_COM:    y = ~b;
            ALU_SWAP:   y = {b[3:0], b[7:4]};   // Nibble swap
            ALU_DEC:    y = b - 1'b1;
            ALU_INC:    y = b + 1'b1;
            ALU_PASS_A: y = a;
            ALU_PASS_B: y = b;
            default:    y = '0;   // ALU_ZERO
        endcase
    end

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import risc_pkg::*;
#(
    parameter int PC_W = PC_W_DEF
)
(
    input  logic            clk,
    input  logic            rst,
    input  pc_sel_e         pc_sel,
    input  logic [PC_W-1:0] goto_target,
    output logic [PC_W-1:0] imem_addr
);

    logic [PC_W-1:0] pc_q;      // Address of the word now in decode
    logic [PC_W-1:0] pc_next;

    // Next fetch address goes straight to the synchronous program memory
    always_comb
    begin
        if (rst)
        begin
            pc_next = '0;   // Reset entry
        end
        else if (pc_sel == PC_GOTO)
        begin
            pc_next = goto_target;
        end
        else
        begin
            pc_next = pc_q + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc_q <= '0;
        else
            pc_q <= pc_next;
    end

    assign imem_addr = pc_next;

endmodule

//--- verilog/file_regs.sv
`timescale 1ns/1ps

module file_regs import risc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  faddr_t    rd_addr,
    output byte_t     rd_data,
    input  logic      wr_en,
    input  faddr_t    wr_addr,
    input  byte_t     wr_data,
    input  logic      z_flag,
    input  logic      c_flag,
    output logic      dvc_wr,
    output logic      dvc_rd,
    output dvc_addr_t dvc_wr_addr,
    output dvc_addr_t dvc_rd_addr,
    output byte_t     data_mem2dvc,
    input  byte_t     data_dvc2mem
);

    localparam int GPR_N = 2**FILE_AW - GPR_BASE;

    byte_t gpr_mem [GPR_N];   // General registers only

    logic  rd_is_gpr, rd_is_dvc, rd_is_stat;
    logic  wr_is_gpr, wr_is_dvc;
    byte_t status_byte;
    byte_t rd_mux;

    assign rd_is_gpr  = (rd_addr >= GPR_BASE);
    assign rd_is_dvc  = (rd_addr >= DVC_BASE) && !rd_is_gpr;
    assign rd_is_stat = (rd_addr == STATUS_ADDR);
    assign wr_is_gpr  = (wr_addr >= GPR_BASE);
    assign wr_is_dvc  = (wr_addr >= DVC_BASE) && !wr_is_gpr;

    always_comb
    begin
        status_byte        = '0;
        status_byte[Z_BIT] = z_flag;
        status_byte[C_BIT] = c_flag;
    end

    always_comb
    begin
        if (rd_is_gpr)
            rd_mux = (wr_en && wr_addr == rd_addr) ? wr_data   // Forward from execute
                                                   : gpr_mem[rd_addr - GPR_BASE];
        else if (rd_is_dvc)
            rd_mux = data_dvc2mem;
        else if (rd_is_stat)
            rd_mux = status_byte;
        else
            rd_mux = '0;
    end

    // Read strobe lives in the decode cycle
    assign dvc_rd      = rd_is_dvc && !rst;
    assign dvc_rd_addr = dvc_addr_t'(rd_addr - DVC_BASE);

    always_ff @(posedge clk)
    begin
        rd_data <= rd_mux;
        if (wr_en && wr_is_gpr)
            gpr_mem[wr_addr - GPR_BASE] <= wr_data;
        if (wr_en && wr_is_dvc)
        begin
            dvc_wr_addr  <= dvc_addr_t'(wr_addr - DVC_BASE);
            data_mem2dvc <= wr_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            dvc_wr <= 1'b0;
        else
            dvc_wr <= wr_en && wr_is_dvc;   // One cycle after execute
    end

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import risc_pkg::*;
(
    input  instr_t  instr,
    output alu_op_e alu_op,
    output src_a_e  src_a,
    output src_b_e  src_b,
    output pc_sel_e pc_sel,
    output logic    file_wr,
    output logic    w_wr,
    output logic    z_wr,
    output logic    c_wr
);

    // Opcode field [9:6] of the byte-oriented group
    typedef enum logic [3:0] {
        BOP_MOVWF = 4'h0,
        BOP_CLR   = 4'h1,
        BOP_SUBWF = 4'h2,
        BOP_DECF  = 4'h3,
        BOP_IORWF = 4'h4,
        BOP_ANDWF = 4'h5,
        BOP_XORWF = 4'h6,
        BOP_ADDWF = 4'h7,
        BOP_MOVF  = 4'h8,
        BOP_COMF  = 4'h9,
        BOP_INCF  = 4'hA,
        BOP_RRF   = 4'hC,
        BOP_RLF   = 4'hD,
        BOP_SWAPF = 4'hE
    } byte_op_e;

    byte_op_e bop;
    logic     d_bit;      // 1 sends the result to the file register
    logic     byte_op;    // Destination follows d

    assign bop   = byte_op_e'(instr[9:6]);
    assign d_bit = instr[5];

    always_comb
    begin
        // NOP unless matched below
        alu_op  = ALU_PASS_B;
        src_a   = SRC_A_NONE;
        src_b   = SRC_B_FILE;
        pc_sel  = PC_NEXT;
        file_wr = 1'b0;
        w_wr    = 1'b0;
        z_wr    = 1'b0;
        c_wr    = 1'b0;
        byte_op = 1'b0;

        casez (instr[11:8])
            4'b00??:
            begin
                case (bop)
                    BOP_MOVWF:
                    begin
                        if (d_bit)   // d clear here is NOP and the like
                        begin
                            src_a   = SRC_A_W;
                            alu_op  = ALU_PASS_A;
                            file_wr = 1'b1;
                        end
                    end
                    BOP_CLR:
                    begin
                        // CLRF with d set, CLRW only as the exact word
                        if (d_bit || instr[4:0] == '0)
                        begin
                            alu_op  = ALU_ZERO;
                            z_wr    = 1'b1;
                            byte_op = 1'b1;
                        end
                    end
                    BOP_SUBWF: begin alu_op = ALU_SUB; src_a = SRC_A_W; z_wr = 1'b1;
                        c_wr = 1'b1; byte_op = 1'b1; end
                    BOP_DECF:  begin alu_op = ALU_DEC; z_wr = 1'b1; byte_op = 1'b1; end
                    BOP_IORWF: begin alu_op = ALU_OR;  src_a = SRC_A_W; z_wr = 1'b1;
                        byte_op = 1'b1; end
                    BOP_ANDWF: begin alu_op = ALU_AND; src_a = SRC_A_W; z_wr = 1'b1;
                        byte_op = 1'b1; end
                    BOP_XORWF: begin alu_op = ALU_XOR; src_a = SRC_A_W; z_wr = 1'b1;
                        byte_op = 1'b1; end
                    BOP_ADDWF: begin alu_op = ALU_ADD; src_a = SRC_A_W; z_wr = 1'b1;
                        c_wr = 1'b1; byte_op = 1'b1; end
                    BOP_MOVF:
                    begin
                        alu_op = ALU_PASS_B;
                        z_wr   = 1'b1;
                        w_wr   = ~d_bit;   // d set only tests the register
                    end
                    BOP_COMF:  begin alu_op = ALU_COM;  z_wr = 1'b1; byte_op = 1'b1; end
                    BOP_INCF:  begin alu_op = ALU_INC;  z_wr = 1'b1; byte_op = 1'b1; end
                    BOP_RRF:   begin alu_op = ALU_ROR;  c_wr = 1'b1; byte_op = 1'b1; end
                    BOP_RLF:   begin alu_op = ALU_ROL;  c_wr = 1'b1; byte_op = 1'b1; end
                    BOP_SWAPF: begin alu_op = ALU_SWAP; byte_op = 1'b1; end
                    default: ;   // Skips run as NOP
                endcase
            end
            4'b101?: pc_sel = PC_GOTO;   // Target taken from instr[8:0]
            4'b1100:
            begin
                src_b  = SRC_B_LIT;
                alu_op = ALU_PASS_B;   // MOVLW leaves Z alone
                w_wr   = 1'b1;
            end
            4'b1101: begin src_b = SRC_B_LIT; src_a = SRC_A_W; alu_op = ALU_OR;
                w_wr = 1'b1; z_wr = 1'b1; end
            4'b1110: begin src_b = SRC_B_LIT; src_a = SRC_A_W; alu_op = ALU_AND;
                w_wr = 1'b1; z_wr = 1'b1; end
            4'b1111: begin src_b = SRC_B_LIT; src_a = SRC_A_W; alu_op = ALU_XOR;
                w_wr = 1'b1; z_wr = 1'b1; end
            default: ;   // Bit ops, CALL, RETLW
        endcase

        if (byte_op)
        begin
            file_wr = d_bit;
            w_wr    = ~d_bit;
        end
    end

endmodule

//--- verilog/risc_core.sv
`timescale 1ns/1ps

module risc_core import risc_pkg::*;
#(
    parameter int PC_W = PC_W_DEF
)
(
    input  logic            clk,
    input  logic            rst,
    output logic [PC_W-1:0] imem_addr,
    input  instr_t          imem_data,
    output logic            dvc_wr,
    output logic            dvc_rd,
    output dvc_addr_t       dvc_wr_addr,
    output dvc_addr_t       dvc_rd_addr,
    output byte_t           data_mem2dvc,
    input  byte_t           data_dvc2mem
);

    // Decode stage
    alu_op_e dec_alu_op;
    src_a_e  dec_src_a;
    src_b_e  dec_src_b;
    pc_sel_e dec_pc_sel;
    logic    dec_file_wr, dec_w_wr, dec_z_wr, dec_c_wr;

    // Execute stage
    alu_op_e ex_alu_op;
    src_a_e  ex_src_a;
    src_b_e  ex_src_b;
    logic    ex_file_wr, ex_w_wr, ex_z_wr, ex_c_wr;
    byte_t   ex_lit;
    faddr_t  ex_wr_addr;

    byte_t   w_reg;
    logic    z_flag, c_flag;
    logic    z_next, c_next;
    byte_t   file_rd, alu_a, alu_b, alu_y;
    logic    alu_c;

    fetch_unit #(.PC_W(PC_W)) u_fetch (
        .clk         (clk),
        .rst         (rst),
        .pc_sel      (dec_pc_sel),
        .goto_target (imem_data[PC_W-1:0]),
        .imem_addr   (imem_addr)
    );

    instr_decoder u_dec (
        .instr   (imem_data),
        .alu_op  (dec_alu_op),
        .src_a   (dec_src_a),
        .src_b   (dec_src_b),
        .pc_sel  (dec_pc_sel),
        .file_wr (dec_file_wr),
        .w_wr    (dec_w_wr),
        .z_wr    (dec_z_wr),
        .c_wr    (dec_c_wr)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ex_alu_op  <= ALU_ZERO;
            ex_src_a   <= SRC_A_NONE;
            ex_src_b   <= SRC_B_FILE;
            {ex_file_wr, ex_w_wr, ex_z_wr, ex_c_wr} <= '0;
        end
        else
        begin
            ex_alu_op  <= dec_alu_op;
            ex_src_a   <= dec_src_a;
            ex_src_b   <= dec_src_b;
            {ex_file_wr, ex_w_wr, ex_z_wr, ex_c_wr} <=
                {dec_file_wr, dec_w_wr, dec_z_wr, dec_c_wr};
        end
    end

    always_ff @(posedge clk)
    begin
        ex_lit     <= imem_data[DATA_W-1:0];
        ex_wr_addr <= imem_data[FILE_AW-1:0];
    end

    assign alu_a = (ex_src_a == SRC_A_W) ? w_reg : '0;
    assign alu_b = (ex_src_b == SRC_B_LIT) ? ex_lit : file_rd;

    alu u_alu (.op(ex_alu_op), .a(alu_a), .b(alu_b), .c_in(c_flag), .y(alu_y), .c_out(alu_c));

    // Flags as they will be after this cycle, so a status read sees them
    assign z_next = ex_z_wr ? (alu_y == '0) : z_flag;
    assign c_next = ex_c_wr ? alu_c : c_flag;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            w_reg  <= '0;
            z_flag <= 1'b0;
            c_flag <= 1'b0;
        end
        else
        begin
            if (ex_w_wr)
                w_reg <= alu_y;
            z_flag <= z_next;
            c_flag <= c_next;
        end
    end

    file_regs u_file (
        .clk          (clk),
        .rst          (rst),
        .rd_addr      (imem_data[FILE_AW-1:0]),
        .rd_data      (file_rd),
        .wr_en        (ex_file_wr),
        .wr_addr      (ex_wr_addr),
        .wr_data      (alu_y),
        .z_flag       (z_next),
        .c_flag       (c_next),
        .dvc_wr       (dvc_wr),
        .dvc_rd       (dvc_rd),
        .dvc_wr_addr  (dvc_wr_addr),
        .dvc_rd_addr  (dvc_rd_addr),
        .data_mem2dvc (data_mem2dvc),
        .data_dvc2mem (data_dvc2mem)
    );

endmodule

//--- verilog/risc_pkg.sv
package risc_pkg;

    // Widths
    localparam int INSTR_W  = 12;
    localparam int DATA_W   = 8;
    localparam int FILE_AW  = 5;
    localparam int PC_W_DEF = 9;   // GOTO carries 9 target bits

    typedef logic [DATA_W-1:0]  byte_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [FILE_AW-1:0] faddr_t;
    typedef logic [1:0]         dvc_addr_t;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,   // B minus A
        ALU_ROR    = 4'h2,
        ALU_ROL    = 4'h3,
        ALU_OR     = 4'h4,
        ALU_XOR    = 4'h5,
        ALU_AND    = 4'h6,
        ALU_COM    = 4'h7,
        ALU_SWAP   = 4'h8,
        ALU_DEC    = 4'h9,
        ALU_INC    = 4'hA,
        ALU_PASS_A = 4'hB,
        ALU_PASS_B = 4'hC,
        ALU_ZERO   = 4'hD
    } alu_op_e;

    // Operand A is W or a constant zero
    typedef enum logic {
        SRC_A_NONE = 1'b0,
        SRC_A_W    = 1'b1
    } src_a_e;

    typedef enum logic {
        SRC_B_FILE = 1'b0,
        SRC_B_LIT  = 1'b1
    } src_b_e;

    typedef enum logic {
        PC_NEXT = 1'b0,
        PC_GOTO = 1'b1
    } pc_sel_e;

    // File map
    // 0..2 read as zero, 3 status, 4..7 device ports, 8..31 general registers
    localparam faddr_t STATUS_ADDR = 5'd3;
    localparam faddr_t DVC_BASE    = 5'd4;
    localparam faddr_t GPR_BASE    = 5'd8;

    // Status byte layout
    localparam int C_BIT = 0;
    localparam int Z_BIT = 2;

endpackage

//--- vlog.f
verilog/risc_pkg.sv
verilog/fetch_unit.sv
verilog/instr_decoder.sv
verilog/alu.sv
verilog/file_regs.sv
verilog/risc_core.sv
tb/tb_clkgen.sv
tb/risc_tb.sv
